//--- cpu_pkg.sv
/*
 * core-facing widths and load/store size codes
 * size code bit 2 marks an unsigned load, bits 1:0 give the access size
 * only byte, halfword and word sizes exist in RV32I
 */
package cpu_pkg;

	// data and address width
	localparam int xlen = 32;
	localparam int reg_adr_w = 5;
	localparam int ldst_code_w = 3;

	// funct3 codes for loads and stores
	localparam logic [ldst_code_w-1:0] ls_b = 3'b000;
	localparam logic [ldst_code_w-1:0] ls_h = 3'b001;
	localparam logic [ldst_code_w-1:0] ls_w = 3'b010;
	localparam logic [ldst_code_w-1:0] ls_bu = 3'b100;
	localparam logic [ldst_code_w-1:0] ls_hu = 3'b101;

	// size field, low two bits of the code
	localparam logic [1:0] sz_byte = 2'b00;
	localparam logic [1:0] sz_half = 2'b01;
	localparam logic [1:0] sz_word = 2'b10;

endpackage

//--- map_pkg.sv
/*
 * address map and memory sizing
 * IO is selected by address bits 31:30 and indexed by bits 5:2, so it aliases
 * the RAM is indexed by bits 9:2 and aliases as well
 * ram_waits must be at least 1
 */
package map_pkg;

	// region select on the top two address bits
	localparam logic [1:0] io_tag = 2'b11;

	localparam int io_regs_n = 16;
	localparam int io_adr_w = 4;

	// external memory model
	localparam int ram_words = 256;
	localparam int ram_adr_w = $clog2(ram_words);
	localparam int ram_waits = 3;

	// wait counter width
	localparam int wait_cnt_w = $clog2(ram_waits + 1);

endpackage

//--- load_align.sv
`timescale 1ns/1ps
/*
 * load data aligner, purely combinational
 * halfword offsets use only bit 1 of the byte offset
 * word loads and unknown size codes pass the raw word through
 */
module load_align (
	input  logic [cpu_pkg::xlen-1:0] raw_word,
	input  logic [cpu_pkg::ldst_code_w-1:0] ldst_code,
	input  logic [1:0] byte_off,
	output logic [cpu_pkg::xlen-1:0] aligned
);

	logic [cpu_pkg::xlen-1:0] byte_shift;
	logic [cpu_pkg::xlen-1:0] half_shift;
	logic [7:0] lane_b;
	logic [15:0] lane_h;
	logic is_unsigned;

	// move the addressed lane down to bit 0
	assign byte_shift = raw_word >> {byte_off, 3'b000};
	assign half_shift = raw_word >> {byte_off[1], 4'b0000};
	assign lane_b = byte_shift[7:0];
	assign lane_h = half_shift[15:0];
	assign is_unsigned = ldst_code[2];

	always_comb begin
		case (ldst_code[1:0])
			cpu_pkg::sz_byte: begin
				if (is_unsigned)
					aligned = {{(cpu_pkg::xlen-8){1'b0}}, lane_b};
				else
					aligned = {{(cpu_pkg::xlen-8){lane_b[7]}}, lane_b};
			end
			cpu_pkg::sz_half: begin
				if (is_unsigned)
					aligned = {{(cpu_pkg::xlen-16){1'b0}}, lane_h};
				else
					aligned = {{(cpu_pkg::xlen-16){lane_h[15]}}, lane_h};
			end
			default: aligned = raw_word;
		endcase
	end

endmodule

//--- data_access.sv
`timescale 1ns/1ps
/*
 * load/store access stage, one access in flight at a time
 * commands are taken only while run is low; misaligned accesses are not trapped
 * sub-word IO stores are dropped without writing
 * IO loads finish one cycle after acceptance, RAM accesses on their completion pulse
 */
module data_access (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_ld,
	input  logic cmd_st,
	input  logic [cpu_pkg::xlen-1:0] addr,
	input  logic [cpu_pkg::xlen-1:0] st_data,
	input  logic [cpu_pkg::ldst_code_w-1:0] ldst_code,
	input  logic [cpu_pkg::reg_adr_w-1:0] rd_adr,
	output logic run,
	output logic rd_req,
	output logic wr_req,
	output logic [cpu_pkg::xlen-1:0] mem_adr,
	output logic [cpu_pkg::xlen-1:0] mem_wdata,
	output logic [3:0] mem_be,
	input  logic rd_valid,
	input  logic wr_finish,
	input  logic [cpu_pkg::xlen-1:0] mem_rdata,
	output logic io_we,
	output logic io_re,
	output logic [map_pkg::io_adr_w-1:0] io_adr,
	output logic [cpu_pkg::xlen-1:0] io_wdata,
	input  logic [cpu_pkg::xlen-1:0] io_rdata,
	output logic wbk_valid,
	output logic [cpu_pkg::reg_adr_w-1:0] wbk_rd_adr,
	output logic [cpu_pkg::xlen-1:0] wbk_data
);

	typedef enum logic [2:0] {idle, mem_read, mem_write, io_read, io_write} state_t;

	state_t state;
	state_t state_nxt;
	logic accept;
	logic sel_io;
	logic [3:0] be_nxt;
	logic [cpu_pkg::xlen-1:0] wdata_nxt;
	logic [cpu_pkg::xlen-1:0] adr_q;
	logic [cpu_pkg::xlen-1:0] wdata_q;
	logic [3:0] be_q;
	logic [cpu_pkg::ldst_code_w-1:0] code_q;
	logic [cpu_pkg::reg_adr_w-1:0] rd_adr_q;
	logic [cpu_pkg::xlen-1:0] raw_word;

	assign accept = (cmd_ld | cmd_st) & ~run;
	assign sel_io = (addr[cpu_pkg::xlen-1 -: 2] == map_pkg::io_tag);
	assign run = (state != idle);

	always_comb begin
		state_nxt = state;
		case (state)
			idle: begin
				if (accept) begin
					if (sel_io)
						state_nxt = cmd_ld ? io_read : io_write;
					else
						state_nxt = cmd_ld ? mem_read : mem_write;
				end
			end
			mem_read: if (rd_valid) state_nxt = idle;
			mem_write: if (wr_finish) state_nxt = idle;
			default: state_nxt = idle;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			state <= idle;
		else
			state <= state_nxt;
	end

	// byte lanes and replicated store data
	always_comb begin
		case (ldst_code[1:0])
			cpu_pkg::sz_byte: begin
				be_nxt = 4'b0001 << addr[1:0];
				wdata_nxt = {4{st_data[7:0]}};
			end
			cpu_pkg::sz_half: begin
				be_nxt = 4'b0011 << {addr[1], 1'b0};
				wdata_nxt = {2{st_data[15:0]}};
			end
			default: begin
				be_nxt = 4'b1111;
				wdata_nxt = st_data;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			adr_q <= addr;
			wdata_q <= wdata_nxt;
			be_q <= be_nxt;
			code_q <= ldst_code;
			rd_adr_q <= rd_adr;
		end
	end

	assign rd_req = (state == mem_read);
	assign wr_req = (state == mem_write);
	assign mem_adr = adr_q;
	assign mem_wdata = wdata_q;
	assign mem_be = be_q;

	// IO read is launched at acceptance so data returns one cycle later
	assign io_re = accept & cmd_ld & sel_io;
	// sub-word IO stores are dropped here
	assign io_we = (state == io_write) & (code_q[1:0] == cpu_pkg::sz_word);
	assign io_adr = (state == io_write) ? adr_q[map_pkg::io_adr_w+1:2]
	                                    : addr[map_pkg::io_adr_w+1:2];
	assign io_wdata = wdata_q;

	assign raw_word = (state == io_read) ? io_rdata : mem_rdata;

	load_align u_load_align (
		.raw_word (raw_word),
		.ldst_code(code_q),
		.byte_off (adr_q[1:0]),
		.aligned  (wbk_data)
	);

	assign wbk_valid = (state == io_read) | ((state == mem_read) & rd_valid);
	assign wbk_rd_adr = rd_adr_q;

	// sender must hold off while an access is in flight
	a_no_cmd_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(cmd_ld | cmd_st) |-> !run);

	a_io_word_store: assert property (@(posedge clk) disable iff (!rst_n)
		(accept & cmd_st & !cmd_ld & sel_io) |-> (ldst_code[1:0] == cpu_pkg::sz_word));

	// memory must only complete what was requested
	a_cpl_has_req: assert property (@(posedge clk) disable iff (!rst_n)
		(rd_valid |-> rd_req) and (wr_finish |-> wr_req));

endmodule

//--- io_regs.sv
`timescale 1ns/1ps
/*
 * bank of word-wide IO registers, all clear to zero on reset
 * writes are whole words only; read data appears the cycle after io_re
 * io_rdata holds its last value when no read is issued
 */
module io_regs (
	input  logic clk,
	input  logic rst_n,
	input  logic io_we,
	input  logic io_re,
	input  logic [map_pkg::io_adr_w-1:0] io_adr,
	input  logic [cpu_pkg::xlen-1:0] io_wdata,
	output logic [cpu_pkg::xlen-1:0] io_rdata
);

	logic [cpu_pkg::xlen-1:0] regs [map_pkg::io_regs_n];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < map_pkg::io_regs_n; i++)
				regs[i] <= '0;
		end else if (io_we) begin
			regs[io_adr] <= io_wdata;
		end
	end

	// registered read port
	always_ff @(posedge clk) begin
		if (io_re)
			io_rdata <= regs[io_adr];
	end

	// the stage never writes and reads in the same cycle
	a_no_we_re: assert property (@(posedge clk) disable iff (!rst_n)
		!(io_we && io_re));

endmodule

//--- wait_ram.sv
`timescale 1ns/1ps
/*
 * slow external data memory model with byte-lane writes
 * a request must stay high and stable until its completion pulse
 * the access happens ram_waits edges after the request is first sampled
 * contents are not reset; read before write returns unknown data
 */
module wait_ram (
	input  logic clk,
	input  logic rst_n,
	input  logic rd_req,
	input  logic wr_req,
	input  logic [cpu_pkg::xlen-1:0] mem_adr,
	input  logic [cpu_pkg::xlen-1:0] mem_wdata,
	input  logic [3:0] mem_be,
	output logic rd_valid,
	output logic wr_finish,
	output logic [cpu_pkg::xlen-1:0] mem_rdata
);

	logic [cpu_pkg::xlen-1:0] mem [map_pkg::ram_words];
	logic [map_pkg::ram_adr_w-1:0] word_idx;
	logic busy;
	logic [map_pkg::wait_cnt_w-1:0] cnt;
	logic fire;

	assign word_idx = mem_adr[map_pkg::ram_adr_w+1:2];
	assign fire = busy & (cnt == map_pkg::wait_cnt_w'(map_pkg::ram_waits - 1));

	// wait counter, not restarted while the completion pulse is out
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			cnt <= '0;
			rd_valid <= 1'b0;
			wr_finish <= 1'b0;
		end else begin
			rd_valid <= fire & rd_req;
			wr_finish <= fire & wr_req;
			if (fire) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
			end else if ((rd_req | wr_req) & ~rd_valid & ~wr_finish) begin
				busy <= 1'b1;
				cnt <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (fire & wr_req) begin
			for (int i = 0; i < 4; i++)
				if (mem_be[i])
					mem[word_idx][i*8 +: 8] <= mem_wdata[i*8 +: 8];
		end
		if (fire & rd_req)
			mem_rdata <= mem[word_idx];
	end

	a_one_req: assert property (@(posedge clk) disable iff (!rst_n)
		!(rd_req && wr_req));

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps
/*
 * load/store unit top with IO bank and wait-state RAM
 * commands may only be issued while run is low
 */
module lsu_top (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_ld,
	input  logic cmd_st,
	input  logic [cpu_pkg::xlen-1:0] addr,
	input  logic [cpu_pkg::xlen-1:0] st_data,
	input  logic [cpu_pkg::ldst_code_w-1:0] ldst_code,
	input  logic [cpu_pkg::reg_adr_w-1:0] rd_adr,
	output logic run,
	output logic wbk_valid,
	output logic [cpu_pkg::reg_adr_w-1:0] wbk_rd_adr,
	output logic [cpu_pkg::xlen-1:0] wbk_data
);

	// memory port
	logic rd_req;
	logic wr_req;
	logic [cpu_pkg::xlen-1:0] mem_adr;
	logic [cpu_pkg::xlen-1:0] mem_wdata;
	logic [3:0] mem_be;
	logic rd_valid;
	logic wr_finish;
	logic [cpu_pkg::xlen-1:0] mem_rdata;

	// IO port
	logic io_we;
	logic io_re;
	logic [map_pkg::io_adr_w-1:0] io_adr;
	logic [cpu_pkg::xlen-1:0] io_wdata;
	logic [cpu_pkg::xlen-1:0] io_rdata;

	data_access u_data_access (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_ld    (cmd_ld),
		.cmd_st    (cmd_st),
		.addr      (addr),
		.st_data   (st_data),
		.ldst_code (ldst_code),
		.rd_adr    (rd_adr),
		.run       (run),
		.rd_req    (rd_req),
		.wr_req    (wr_req),
		.mem_adr   (mem_adr),
		.mem_wdata (mem_wdata),
		.mem_be    (mem_be),
		.rd_valid  (rd_valid),
		.wr_finish (wr_finish),
		.mem_rdata (mem_rdata),
		.io_we     (io_we),
		.io_re     (io_re),
		.io_adr    (io_adr),
		.io_wdata  (io_wdata),
		.io_rdata  (io_rdata),
		.wbk_valid (wbk_valid),
		.wbk_rd_adr(wbk_rd_adr),
		.wbk_data  (wbk_data)
	);

	io_regs u_io_regs (
		.clk     (clk),
		.rst_n   (rst_n),
		.io_we   (io_we),
		.io_re   (io_re),
		.io_adr  (io_adr),
		.io_wdata(io_wdata),
		.io_rdata(io_rdata)
	);

	wait_ram u_wait_ram (
		.clk      (clk),
		.rst_n    (rst_n),
		.rd_req   (rd_req),
		.wr_req   (wr_req),
		.mem_adr  (mem_adr),
		.mem_wdata(mem_wdata),
		.mem_be   (mem_be),
		.rd_valid (rd_valid),
		.wr_finish(wr_finish),
		.mem_rdata(mem_rdata)
	);

endmodule

//--- lsu_checker.sv
`timescale 1ns/1ps
/*
 * write-back watcher for the load/store unit testbench
 * expected loads are queued in issue order through push_expect
 * also checks that run rises in the cycle after every accepted command
 */
module lsu_checker (
	input  logic clk,
	input  logic rst_n,
	input  logic cmd_ld,
	input  logic cmd_st,
	input  logic run,
	input  logic wbk_valid,
	input  logic [cpu_pkg::reg_adr_w-1:0] wbk_rd_adr,
	input  logic [cpu_pkg::xlen-1:0] wbk_data,
	output int mismatch_cnt,
	output int protocol_cnt
);

	logic [cpu_pkg::xlen-1:0] exp_data_q [$];
	logic [cpu_pkg::reg_adr_w-1:0] exp_rd_q [$];
	string exp_name_q [$];
	logic acc_prev;
	string cur_name;
	logic [cpu_pkg::xlen-1:0] cur_data;
	logic [cpu_pkg::reg_adr_w-1:0] cur_rd;

	initial begin
		mismatch_cnt = 0;
		protocol_cnt = 0;
	end

	task automatic push_expect(input string name, input logic [cpu_pkg::reg_adr_w-1:0] rd,
		input logic [cpu_pkg::xlen-1:0] data);
		exp_name_q.push_back(name);
		exp_rd_q.push_back(rd);
		exp_data_q.push_back(data);
	endtask

	function automatic int pending_count();
		return exp_data_q.size();
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			acc_prev <= 1'b0;
		end else begin
			acc_prev <= (cmd_ld | cmd_st) & ~run;
			// run must be high in the cycle after acceptance
			if (acc_prev && !run) begin
				$display("run did not rise after an accepted command at %0t", $time);
				protocol_cnt = protocol_cnt + 1;
			end
			if (wbk_valid) begin
				if (exp_data_q.size() == 0) begin
					$display("write-back to x%0d at %0t with no load outstanding",
						wbk_rd_adr, $time);
					protocol_cnt = protocol_cnt + 1;
				end else begin
					cur_name = exp_name_q.pop_front();
					cur_rd = exp_rd_q.pop_front();
					cur_data = exp_data_q.pop_front();
					if (wbk_rd_adr !== cur_rd || wbk_data !== cur_data) begin
						$display("[ERROR] %s: expected x%0d=%08h, actual x%0d=%08h",
							cur_name, cur_rd, cur_data, wbk_rd_adr, wbk_data);
						mismatch_cnt = mismatch_cnt + 1;
					end
				end
			end
		end
	end

endmodule

//--- tb_lsu.sv
`timescale 1ns/1ps
/*
 * testbench for the load/store unit top
 * accesses are issued one at a time on the falling edge, after run is low
 * RAM is filled with word stores before random loads, so no load reads unwritten data
 * IO stores are always whole words; sub-word RAM accesses are kept naturally aligned
 */
module tb_lsu;

	localparam int run_limit = 50;

	logic clk;
	logic rst_n;
	logic cmd_ld;
	logic cmd_st;
	logic [cpu_pkg::xlen-1:0] addr;
	logic [cpu_pkg::xlen-1:0] st_data;
	logic [cpu_pkg::ldst_code_w-1:0] ldst_code;
	logic [cpu_pkg::reg_adr_w-1:0] rd_adr;
	logic run;
	logic wbk_valid;
	logic [cpu_pkg::reg_adr_w-1:0] wbk_rd_adr;
	logic [cpu_pkg::xlen-1:0] wbk_data;
	int mismatch_cnt;
	int protocol_cnt;

	// reference copies of RAM bytes and IO words
	logic [7:0] ref_ram [map_pkg::ram_words*4];
	logic [cpu_pkg::xlen-1:0] ref_io [map_pkg::io_regs_n];
	logic [31:0] lfsr;

	lsu_top u_lsu_top (
		.clk       (clk),
		.rst_n     (rst_n),
		.cmd_ld    (cmd_ld),
		.cmd_st    (cmd_st),
		.addr      (addr),
		.st_data   (st_data),
		.ldst_code (ldst_code),
		.rd_adr    (rd_adr),
		.run       (run),
		.wbk_valid (wbk_valid),
		.wbk_rd_adr(wbk_rd_adr),
		.wbk_data  (wbk_data)
	);

	lsu_checker u_lsu_checker (
		.clk         (clk),
		.rst_n       (rst_n),
		.cmd_ld      (cmd_ld),
		.cmd_st      (cmd_st),
		.run         (run),
		.wbk_valid   (wbk_valid),
		.wbk_rd_adr  (wbk_rd_adr),
		.wbk_data    (wbk_data),
		.mismatch_cnt(mismatch_cnt),
		.protocol_cnt(protocol_cnt)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	function automatic logic [31:0] expected_load(input logic [2:0] code, input logic [31:0] a);
		logic [31:0] word;
		logic [7:0] b;
		logic [15:0] h;
		int base;
		base = int'(a[9:2]) * 4;
		if (a[31:30] == map_pkg::io_tag)
			word = ref_io[a[5:2]];
		else
			word = {ref_ram[base+3], ref_ram[base+2], ref_ram[base+1], ref_ram[base]};
		case (a[1:0])
			2'd0: b = word[7:0];
			2'd1: b = word[15:8];
			2'd2: b = word[23:16];
			default: b = word[31:24];
		endcase
		h = a[1] ? word[31:16] : word[15:0];
		case (code)
			cpu_pkg::ls_b: return {{24{b[7]}}, b};
			cpu_pkg::ls_bu: return {24'h0, b};
			cpu_pkg::ls_h: return {{16{h[15]}}, h};
			cpu_pkg::ls_hu: return {16'h0, h};
			default: return word;
		endcase
	endfunction

	task automatic record_store(input logic [2:0] code, input logic [31:0] a,
		input logic [31:0] d);
		int base;
		base = int'(a[9:0]);
		if (a[31:30] == map_pkg::io_tag) begin
			ref_io[a[5:2]] = d;
		end else if (code == cpu_pkg::ls_b) begin
			ref_ram[base] = d[7:0];
		end else if (code == cpu_pkg::ls_h) begin
			base = base - (base % 2);
			ref_ram[base] = d[7:0];
			ref_ram[base+1] = d[15:8];
		end else begin
			base = base - (base % 4);
			for (int k = 0; k < 4; k++)
				ref_ram[base+k] = d[k*8 +: 8];
		end
	endtask

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d protocol, %0d loads without write-back",
			mismatch_cnt, protocol_cnt, u_lsu_checker.pending_count());
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		print_counts();
		$display("*** TEST FAILED ***");
		$finish;
	endtask

	// one access, then scramble the command fields and wait for run to drop
	task automatic do_access(input string name, input logic ld, input logic [2:0] code,
		input logic [31:0] a, input logic [31:0] d, input logic [4:0] rd);
		int waited;
		if (ld)
			u_lsu_checker.push_expect(name, rd, expected_load(code, a));
		else
			record_store(code, a, d);
		cmd_ld = ld;
		cmd_st = ~ld;
		addr = a;
		st_data = d;
		ldst_code = code;
		rd_adr = rd;
		@(negedge clk);
		cmd_ld = 1'b0;
		cmd_st = 1'b0;
		addr = rand_bits(32);
		st_data = rand_bits(32);
		ldst_code = 3'(rand_bits(3));
		rd_adr = 5'(rand_bits(5));
		waited = 0;
		while (run && waited < run_limit) begin
			@(negedge clk);
			waited++;
		end
		if (run)
			abort_run($sformatf("timeout: run stayed high after access '%s'", name));
	endtask

	task automatic ram_lane_tests();
		logic [31:0] base;
		logic [7:0] val;
		base = 32'h0000_0040;
		do_access("lane clear", 1'b0, cpu_pkg::ls_w, base, 32'h0, 5'd0);
		for (int lane = 0; lane < 4; lane++) begin
			val = 8'h81 ^ (8'(lane) * 8'h3e);
			do_access("byte store", 1'b0, cpu_pkg::ls_b, base + 32'(lane),
				{24'ha5a5a5, val}, 5'd0);
			do_access("byte lane word", 1'b1, cpu_pkg::ls_w, base, 32'h0, 5'(lane + 1));
		end
		for (int lane = 0; lane < 4; lane++) begin
			do_access("lb", 1'b1, cpu_pkg::ls_b, base + 32'(lane), 32'h0, 5'd7);
			do_access("lbu", 1'b1, cpu_pkg::ls_bu, base + 32'(lane), 32'h0, 5'd8);
		end
		do_access("half clear", 1'b0, cpu_pkg::ls_w, base + 32'd4, 32'hffff_ffff, 5'd0);
		do_access("half store lo", 1'b0, cpu_pkg::ls_h, base + 32'd4, 32'h1234_8a71, 5'd0);
		do_access("half lane word", 1'b1, cpu_pkg::ls_w, base + 32'd4, 32'h0, 5'd9);
		do_access("half store hi", 1'b0, cpu_pkg::ls_h, base + 32'd6, 32'hfedc_6c3e, 5'd0);
		for (int hw = 0; hw < 2; hw++) begin
			do_access("lh", 1'b1, cpu_pkg::ls_h, base + 32'(4 + 2 * hw), 32'h0, 5'd10);
			do_access("lhu", 1'b1, cpu_pkg::ls_hu, base + 32'(4 + 2 * hw), 32'h0, 5'd11);
		end
	endtask

	task automatic random_mix(input int n);
		logic ld;
		logic io;
		logic [2:0] code;
		logic [31:0] a;
		logic [31:0] pick;
		for (int i = 0; i < n; i++) begin
			ld = (rand_bits(1) != 0);
			io = (rand_bits(2) == 0);
			pick = rand_bits(3) % 5;
			if (ld) begin
				case (pick)
					0: code = cpu_pkg::ls_b;
					1: code = cpu_pkg::ls_h;
					2: code = cpu_pkg::ls_w;
					3: code = cpu_pkg::ls_bu;
					default: code = cpu_pkg::ls_hu;
				endcase
			end else if (io) begin
				code = cpu_pkg::ls_w;
			end else begin
				code = (pick % 3 == 0) ? cpu_pkg::ls_b : (pick % 3 == 1) ? cpu_pkg::ls_h
				                                                      : cpu_pkg::ls_w;
			end
			// upper bits stay random so both regions alias
			a = rand_bits(32);
			if (io)
				a[31:30] = map_pkg::io_tag;
			else if (a[31:30] == map_pkg::io_tag)
				a[31] = 1'b0;
			if (code[1:0] == cpu_pkg::sz_word)
				a[1:0] = 2'b00;
			else if (code[1:0] == cpu_pkg::sz_half)
				a[0] = 1'b0;
			do_access($sformatf("random %0d", i), ld, code, a, rand_bits(32),
				5'(rand_bits(5)));
		end
	endtask

	initial begin
		cmd_ld = 1'b0;
		cmd_st = 1'b0;
		addr = '0;
		st_data = '0;
		ldst_code = '0;
		rd_adr = '0;
		lfsr = 32'hf708_ae58;
		for (int i = 0; i < map_pkg::io_regs_n; i++)
			ref_io[i] = '0;
		rst_n = 1'b0;
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);

		// IO bank reads zero after reset
		for (int i = 0; i < map_pkg::io_regs_n; i++)
			do_access("io reset value", 1'b1, cpu_pkg::ls_w, 32'hc000_0000 + 32'(4 * i),
				32'h0, 5'(i));

		do_access("ram word store", 1'b0, cpu_pkg::ls_w, 32'h0000_0100, 32'hcafe_f00d, 5'd0);
		do_access("ram word load", 1'b1, cpu_pkg::ls_w, 32'h0000_0100, 32'h0, 5'd5);
		ram_lane_tests();

		do_access("io store", 1'b0, cpu_pkg::ls_w, 32'hc000_000c, 32'h1357_9bdf, 5'd0);
		do_access("io load", 1'b1, cpu_pkg::ls_w, 32'hc000_000c, 32'h0, 5'd12);
		do_access("io alias load", 1'b1, cpu_pkg::ls_w, 32'hffff_ffcc, 32'h0, 5'd13);
		do_access("io lh", 1'b1, cpu_pkg::ls_h, 32'hc000_000e, 32'h0, 5'd14);
		do_access("io lbu", 1'b1, cpu_pkg::ls_bu, 32'hc000_000d, 32'h0, 5'd15);

		// every RAM word gets a value that depends on its whole index
		for (int i = 0; i < map_pkg::ram_words; i++)
			do_access("ram fill", 1'b0, cpu_pkg::ls_w, 32'(i * 4),
				{~8'(i), 8'(i) ^ 8'h5a, 8'(i) + 8'h33, 8'(i)}, 5'd0);

		random_mix(200);

		print_counts();
		if (mismatch_cnt == 0 && protocol_cnt == 0 && u_lsu_checker.pending_count() == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- all.f
cpu_pkg.sv
map_pkg.sv
load_align.sv
data_access.sv
io_regs.sv
wait_ram.sv
lsu_top.sv
lsu_checker.sv
tb_lsu.sv

//--- Makefile
# Verilator build and run for the load/store unit testbench
TOP = tb_lsu

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -Mdir obj_dir -o sim_lsu

run: compile
	./obj_dir/sim_lsu > sim.log 2>&1; cat sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log
